/* Makefile */
TOP = tb_trig_acq

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir

run: compile
	obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* list.f */
+incdir+src
src/trig_pkg.sv
src/trig_detect.sv
src/acq_fsm.sv
src/sample_counter.sv
src/capture_ram.sv
src/wb_regs.sv
src/trig_acq_top.sv
testbench/trig_acq_chk.sv
testbench/tb_trig_acq.sv

/* src/acq_fsm.sv */
`timescale 1ns/10ps

module acq_fsm import trig_pkg::*; (
  input  logic       adc_clk,
  input  logic       rst_n,
  input  logic       arm,
  input  logic       trig,
  input  logic       smp_valid,
  input  logic       last,
  output acq_state_e state,
  output logic       cnt_clr,
  output logic       cnt_inc,
  output logic       wr_en,
  output logic       done
);

  acq_state_e state_nxt;

  //////////////////////////////////////////////////////////////////////
  // Next state and write decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    cnt_clr   = 1'b0;
    wr_en     = 1'b0;
    // Arm wins from any state and restarts the run
    if (arm) begin
      state_nxt = ARMED;
      cnt_clr   = 1'b1;
    end else begin
      case (state)
        ARMED: begin
          // Triggering word itself is word 0
          if (trig) begin
            wr_en     = 1'b1;
            state_nxt = last ? DONE : CAPTURE;
          end
        end
        CAPTURE: begin
          if (smp_valid) begin
            wr_en = 1'b1;
            if (last) begin
              state_nxt = DONE;
            end
          end
        end
        // IDLE and DONE wait for arm
        default: state_nxt = state;
      endcase
    end
  end

  // Counter advances with every stored word
  assign cnt_inc = wr_en;

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Level held until the next arm
  assign done = (state == DONE);

endmodule

/* src/capture_ram.sv */
`timescale 1ns/10ps
`include "trig_defines.svh"

module capture_ram import trig_pkg::*; (
  input  logic              adc_clk,
  input  logic              wr_en,
  input  logic [`CAP_AW-1:0] wr_addr,
  input  sample_t           wr_data,
  input  logic [`CAP_AW-1:0] rd_addr,
  output logic [31:0]       rd_data
);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // One packed sample pair per entry
  logic [31:0] mem [`CAP_DEPTH];

  // Only aligned words are ever written
  always_ff @(posedge adc_clk) begin
    if (wr_en && wr_data.valid) begin
      mem[wr_addr] <= wr_data.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // Asynchronous read, the bus slave registers the result
  assign rd_data = mem[rd_addr];

endmodule

/* src/sample_counter.sv */
`timescale 1ns/10ps
`include "trig_defines.svh"

module sample_counter (
  input  logic              adc_clk,
  input  logic              rst_n,
  input  logic              clr,
  input  logic              inc,
  input  logic [`CAP_AW:0]  count,
  output logic [`CAP_AW-1:0] wr_addr,
  output logic [`CAP_AW:0]  words,
  output logic              last
);

  localparam logic [`CAP_AW:0] FULL = (`CAP_AW+1)'(`CAP_DEPTH);

  logic [`CAP_AW:0] target;
  logic [`CAP_AW:0] words_inc;

  // Zero or out of range means a full buffer
  assign target = ((count == '0) || (count > FULL)) ? FULL : count;

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      words <= '0;
    end else if (clr) begin
      words <= '0;
    end else if (inc) begin
      words <= words_inc;
    end
  end

  assign words_inc = words + 1'b1;

  // Next write lands at the current count
  assign wr_addr = words[`CAP_AW-1:0];

  // High while the pending write is the final one
  assign last = (words_inc == target);

endmodule

/* src/trig_acq_top.sv */
`timescale 1ns/10ps
`include "trig_defines.svh"

module trig_acq_top import trig_pkg::*; (
  input  logic             adc_clk,
  input  logic             rst_n,
  input  adc_ch_t          ch_a,
  input  adc_ch_t          ch_b,
  input  adc_ch_t          ch_c,
  input  adc_ch_t          ch_d,
  output logic             trigger_out,
  output logic             acq_done,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [`CAP_AW:0] wb_adr,
  input  logic [31:0]      wb_dat_i,
  output logic [31:0]      wb_dat_o,
  output logic             wb_ack
);

  acq_cfg_t            cfg;
  logic                arm;
  sample_t             smp;
  acq_state_e          state;
  logic                cnt_clr;
  logic                cnt_inc;
  logic                wr_en;
  logic [`CAP_AW-1:0]  wr_addr;
  logic [`CAP_AW:0]    words;
  logic                last;
  logic [`CAP_AW-1:0]  rd_addr;
  logic [31:0]         rd_data;

  //////////////////////////////////////////////////////////////////////
  // Trigger path
  //////////////////////////////////////////////////////////////////////

  // Pulse leaves the detector two cycles after the crossing word
  trig_detect i_trig_detect (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .ch_a    (ch_a),
    .ch_b    (ch_b),
    .ch_c    (ch_c),
    .ch_d    (ch_d),
    .cfg     (cfg),
    .smp     (smp),
    .trig    (trigger_out)
  );

  acq_fsm i_acq_fsm (
    .adc_clk   (adc_clk),
    .rst_n     (rst_n),
    .arm       (arm),
    .trig      (trigger_out),
    .smp_valid (smp.valid),
    .last      (last),
    .state     (state),
    .cnt_clr   (cnt_clr),
    .cnt_inc   (cnt_inc),
    .wr_en     (wr_en),
    .done      (acq_done)
  );

  //////////////////////////////////////////////////////////////////////
  // Capture storage
  //////////////////////////////////////////////////////////////////////

  sample_counter i_sample_counter (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .clr     (cnt_clr),
    .inc     (cnt_inc),
    .count   (cfg.count),
    .wr_addr (wr_addr),
    .words   (words),
    .last    (last)
  );

  capture_ram i_capture_ram (
    .adc_clk (adc_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (smp),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Host access
  //////////////////////////////////////////////////////////////////////

  wb_regs i_wb_regs (
    .adc_clk  (adc_clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .state    (state),
    .words    (words),
    .rd_data  (rd_data),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack),
    .cfg      (cfg),
    .arm      (arm),
    .rd_addr  (rd_addr)
  );

endmodule

/* src/trig_defines.svh */
`ifndef TRIG_DEFINES_SVH
`define TRIG_DEFINES_SVH

// One ADC sample, two of them packed per channel word
`define SMP_W 16

// Sign-extended pair sum with headroom for the add
`define SUM_W 18

// Capture buffer geometry
`define CAP_DEPTH 64
`define CAP_AW 6

// Wishbone word offsets of the control registers
`define REG_CTRL 0
`define REG_LEVEL 1
`define REG_COUNT 2
`define REG_STATUS 3

// Start of the buffer read window
`define BUF_BASE 64

`endif

/* src/trig_detect.sv */
`timescale 1ns/10ps
`include "trig_defines.svh"

module trig_detect import trig_pkg::*; (
  input  logic     adc_clk,
  input  logic     rst_n,
  input  adc_ch_t  ch_a,
  input  adc_ch_t  ch_b,
  input  adc_ch_t  ch_c,
  input  adc_ch_t  ch_d,
  input  acq_cfg_t cfg,
  output sample_t  smp,
  output logic     trig
);

  adc_ch_t                  sel;
  logic                     s1_valid;
  logic [2*`SMP_W-1:0]      s1_data;
  logic signed [`SUM_W-1:0] s1_sum;
  logic                     gt;
  logic                     gt_prev;
  logic                     s2_valid;
  logic [2*`SMP_W-1:0]      s2_data;

  // Both halves sign-extended and added, twice the mean of the pair
  function automatic logic signed [`SUM_W-1:0] pair_sum(input logic [2*`SMP_W-1:0] w);
    logic signed [`SUM_W-1:0] lo;
    logic signed [`SUM_W-1:0] hi;
    lo = $signed({{(`SUM_W-`SMP_W){w[`SMP_W-1]}}, w[`SMP_W-1:0]});
    hi = $signed({{(`SUM_W-`SMP_W){w[2*`SMP_W-1]}}, w[2*`SMP_W-1:`SMP_W]});
    return lo + hi;
  endfunction

  // Channel select
  always_comb begin
    case (cfg.chan)
      2'd0:    sel = ch_a;
      2'd1:    sel = ch_b;
      2'd2:    sel = ch_c;
      default: sel = ch_d;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Stage one
  //////////////////////////////////////////////////////////////////////

  // A word only counts when its channel is enabled and valid
  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= sel.en & sel.valid;
    end
  end

  always_ff @(posedge adc_clk) begin
    s1_data <= sel.data;
    s1_sum  <= pair_sum(sel.data);
  end

  //////////////////////////////////////////////////////////////////////
  // Stage two
  //////////////////////////////////////////////////////////////////////

  // Signed compare against the programmed level
  assign gt = (s1_sum > $signed(cfg.level));

  // Edge history moves only on qualified words
  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
      trig     <= 1'b0;
      gt_prev  <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
      trig     <= s1_valid & gt & ~gt_prev;
      if (s1_valid) begin
        gt_prev <= gt;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    s2_data <= s1_data;
  end

  // Word leaves together with its trigger pulse
  assign smp = '{data: s2_data, valid: s2_valid};

endmodule

/* src/trig_pkg.sv */
`include "trig_defines.svh"

package trig_pkg;

  // One digitizer channel as delivered by the front end
  typedef struct packed {
    logic [2*`SMP_W-1:0] data;
    logic                en;
    logic                valid;
  } adc_ch_t;

  // Selected word after the detector pipeline
  typedef struct packed {
    logic [2*`SMP_W-1:0] data;
    logic                valid;
  } sample_t;

  // Acquisition setup held in the register block
  typedef struct packed {
    logic signed [`SUM_W-1:0] level;
    logic [1:0]               chan;
    logic [`CAP_AW:0]         count;
  } acq_cfg_t;

  typedef enum logic [1:0] {
    IDLE,
    ARMED,
    CAPTURE,
    DONE
  } acq_state_e;

  // Register word offsets on the Wishbone side
  typedef enum logic [`CAP_AW:0] {
    ADDR_CTRL   = (`CAP_AW+1)'(`REG_CTRL),
    ADDR_LEVEL  = (`CAP_AW+1)'(`REG_LEVEL),
    ADDR_COUNT  = (`CAP_AW+1)'(`REG_COUNT),
    ADDR_STATUS = (`CAP_AW+1)'(`REG_STATUS)
  } reg_addr_e;

endpackage

/* src/wb_regs.sv */
`timescale 1ns/10ps
`include "trig_defines.svh"

module wb_regs import trig_pkg::*; (
  input  logic              adc_clk,
  input  logic              rst_n,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [`CAP_AW:0]  wb_adr,
  input  logic [31:0]       wb_dat_i,
  input  acq_state_e        state,
  input  logic [`CAP_AW:0]  words,
  input  logic [31:0]       rd_data,
  output logic [31:0]       wb_dat_o,
  output logic              wb_ack,
  output acq_cfg_t          cfg,
  output logic              arm,
  output logic [`CAP_AW-1:0] rd_addr
);

  logic        req;
  logic        wr_stb;
  logic        buf_sel;
  logic [31:0] rd_mux;

  //////////////////////////////////////////////////////////////////////
  // Bus handshake
  //////////////////////////////////////////////////////////////////////

  // New request only while ack is low, so ack lasts one cycle
  assign req     = wb_cyc & wb_stb & ~wb_ack;
  assign wr_stb  = req & wb_we;
  assign buf_sel = (wb_adr >= (`CAP_AW+1)'(`BUF_BASE));

  // Low address bits index the capture buffer
  assign rd_addr = wb_adr[`CAP_AW-1:0];

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg.level <= '0;
      cfg.chan  <= '0;
      cfg.count <= {{`CAP_AW{1'b0}}, 1'b1};
      arm       <= 1'b0;
    end else begin
      // Arm is a one cycle strobe
      arm <= 1'b0;
      if (wr_stb && !buf_sel) begin
        case (wb_adr)
          ADDR_CTRL: begin
            arm      <= wb_dat_i[0];
            cfg.chan <= wb_dat_i[2:1];
          end
          ADDR_LEVEL: cfg.level <= wb_dat_i[`SUM_W-1:0];
          ADDR_COUNT: cfg.count <= wb_dat_i[`CAP_AW:0];
          // Status and unmapped offsets ignore writes
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;
    if (buf_sel) begin
      rd_mux = rd_data;
    end else begin
      case (wb_adr)
        // Arm bit always reads back as zero
        ADDR_CTRL:   rd_mux = {29'd0, cfg.chan, 1'b0};
        ADDR_LEVEL:  rd_mux = {{(32-`SUM_W){1'b0}}, cfg.level};
        ADDR_COUNT:  rd_mux = {{(31-`CAP_AW){1'b0}}, cfg.count};
        // Words written in 14:8, FSM state in 1:0
        ADDR_STATUS: rd_mux = {17'd0, words, 6'd0, state};
        default:     rd_mux = '0;
      endcase
    end
  end

  // Captured at the request edge, valid while ack is high
  always_ff @(posedge adc_clk) begin
    if (req && !wb_we) begin
      wb_dat_o <= rd_mux;
    end
  end

endmodule

/* testbench/tb_trig_acq.sv */
`timescale 1ns/10ps
`include "trig_defines.svh"

module tb_trig_acq import trig_pkg::*; ();

  logic             adc_clk;
  logic             rst_n;
  adc_ch_t          ch_in [4];
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [`CAP_AW:0] wb_adr;
  logic [31:0]      wb_dat_i;
  logic [31:0]      wb_dat_o;
  logic             wb_ack;
  logic             trigger_out;
  logic             acq_done;

  int          seed = 91114;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          trig_cnt = 0;
  int          model_level = 0;
  bit          model_prev = 1'b0;
  logic [3:0]  en_mask = 4'hf;
  logic [31:0] stim [$];

  trig_acq_top i_trig_acq_top (
    .adc_clk     (adc_clk),
    .rst_n       (rst_n),
    .ch_a        (ch_in[0]),
    .ch_b        (ch_in[1]),
    .ch_c        (ch_in[2]),
    .ch_d        (ch_in[3]),
    .trigger_out (trigger_out),
    .acq_done    (acq_done),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack      (wb_ack)
  );

  bind trig_acq_top trig_acq_chk i_trig_acq_chk (
    .adc_clk (adc_clk), .rst_n (rst_n), .wb_cyc (wb_cyc), .wb_stb (wb_stb),
    .wb_ack (wb_ack), .trigger_out (trigger_out), .wr_en (wr_en),
    .state (state), .words (words), .cfg (cfg)
  );

  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  // Pulses counted mid-cycle where the output is settled
  always @(negedge adc_clk) begin
    if (trigger_out) trig_cnt++;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////////////////////////

  // Both 16-bit halves as signed numbers, added at full precision
  function automatic int pair_value(input logic [31:0] w);
    int lo;
    int hi;
    lo = int'($signed(w[15:0]));
    hi = int'($signed(w[31:16]));
    return lo + hi;
  endfunction

  function automatic bit model_gt(input logic [31:0] w, input int level);
    return pair_value(w) > level;
  endfunction

  // Two samples at base plus a random offset below spread
  function automatic logic [31:0] rand_pair(input int base, input int spread);
    int s0;
    int s1;
    s0 = base + ($random(seed) % spread);
    s1 = base + ($random(seed) % spread);
    return {s1[15:0], s0[15:0]};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus and ADC drivers
  //////////////////////////////////////////////////////////////////////

  // Returns at the negedge where ack is seen
  task automatic wait_ack();
    int n;
    n = 0;
    @(negedge adc_clk);
    while (!wb_ack && n < 20) begin
      @(negedge adc_clk);
      n++;
    end
    if (!wb_ack) stop_on_timeout("Wishbone ack");
  endtask

  // Strobe held until the edge where the master samples ack
  task automatic bus_release();
    @(posedge adc_clk);
    #5;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input int adr, input logic [31:0] data);
    @(posedge adc_clk);
    #5;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = 7'(adr);
    wb_dat_i = data;
    wait_ack();
    bus_release();
  endtask

  task automatic wb_read(input int adr, output logic [31:0] data);
    @(posedge adc_clk);
    #5;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = 7'(adr);
    wait_ack();
    data = wb_dat_o;
    bus_release();
  endtask

  // Selected channel carries w, the others a per-channel variant when mixing
  task automatic adc_push(input logic [31:0] w, input int chan, input bit mix);
    @(posedge adc_clk);
    #5;
    for (int k = 0; k < 4; k++) begin
      ch_in[k].data  = (mix && k != chan) ? (w ^ (32'h1111_1111 * (k + 1))) : w;
      ch_in[k].en    = en_mask[k];
      ch_in[k].valid = 1'b1;
    end
    if (en_mask[chan]) model_prev = model_gt(w, model_level);
  endtask

  // Drop valid and let the two-stage detector drain
  task automatic adc_idle();
    @(posedge adc_clk);
    #5;
    for (int k = 0; k < 4; k++) ch_in[k].valid = 1'b0;
    repeat (4) @(posedge adc_clk);
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    @(negedge adc_clk);
    while (!acq_done && n < 500) begin
      @(negedge adc_clk);
      n++;
    end
    if (!acq_done) stop_on_timeout("acq_done");
  endtask

  task automatic program_cfg(input int chan, input int level, input int cnt);
    wb_write(ADDR_CTRL, 32'(chan << 1));
    wb_write(ADDR_LEVEL, 32'(level));
    wb_write(ADDR_COUNT, 32'(cnt));
    model_level = level;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Capture run against the model
  //////////////////////////////////////////////////////////////////////

  task automatic capture_run(input int chan, input int level, input int cnt, input bit mix);
    int          depth;
    int          trig_idx;
    int          exp_trigs;
    int          t0;
    bit          prev;
    bit          g;
    logic [31:0] rd;
    depth = (cnt == 0) ? `CAP_DEPTH : cnt;
    program_cfg(chan, level, cnt);
    wb_write(ADDR_CTRL, 32'((chan << 1) | 1));
    wb_read(ADDR_STATUS, rd);
    check_eq("STATUS after arm", rd, 32'(ARMED));
    // Done level drops as soon as the run is armed
    check_eq("acq_done after arm", 32'(acq_done), 32'h0);
    // Expected pulses from the rising edges of the compare
    prev      = model_prev;
    trig_idx  = -1;
    exp_trigs = 0;
    foreach (stim[i]) begin
      g = model_gt(stim[i], level);
      if (g && !prev) begin
        exp_trigs++;
        if (trig_idx < 0) trig_idx = i;
      end
      prev = g;
    end
    t0 = trig_cnt;
    foreach (stim[i]) adc_push(stim[i], chan, mix);
    adc_idle();
    if (trig_idx < 0 || trig_idx + depth > stim.size()) begin
      errors++;
      $display("stimulus holds no trigger with %0d words after it", depth);
    end else begin
      wait_done();
      check_eq("trigger_out pulses", 32'(trig_cnt - t0), 32'(exp_trigs));
      wb_read(ADDR_STATUS, rd);
      check_eq("STATUS after capture", rd, 32'((depth << 8) | int'(DONE)));
      for (int n = 0; n < depth; n++) begin
        wb_read(`BUF_BASE + n, rd);
        check_eq($sformatf("buffer[%0d]", n), rd, stim[trig_idx + n]);
      end
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err_start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    int          e0;
    logic [31:0] rd;
    e0 = errors;
    wb_read(ADDR_CTRL, rd);
    check_eq("CTRL", rd, 32'h0);
    wb_read(ADDR_LEVEL, rd);
    check_eq("LEVEL", rd, 32'h0);
    wb_read(ADDR_COUNT, rd);
    check_eq("COUNT", rd, 32'h1);
    wb_read(ADDR_STATUS, rd);
    check_eq("STATUS", rd, 32'(IDLE));
    // Only the low 18 level bits are kept
    wb_write(ADDR_LEVEL, 32'hffff_ff00);
    wb_read(ADDR_LEVEL, rd);
    check_eq("LEVEL", rd, 32'h0003_ff00);
    wb_write(ADDR_COUNT, 32'h25);
    wb_read(ADDR_COUNT, rd);
    check_eq("COUNT", rd, 32'h25);
    wb_write(ADDR_CTRL, 32'h6);
    wb_read(ADDR_CTRL, rd);
    check_eq("CTRL", rd, 32'h6);
    wb_read(ADDR_STATUS, rd);
    check_eq("STATUS", rd, 32'(IDLE));
    report_test("reset_values", e0);
  endtask

  task automatic test_no_trigger();
    int          e0;
    int          t0;
    logic [31:0] rd;
    e0 = errors;
    program_cfg(0, 1000, 4);
    wb_write(ADDR_CTRL, 32'h1);
    t0 = trig_cnt;
    repeat (20) adc_push(rand_pair(0, 400), 0, 1'b0);
    adc_idle();
    check_eq("trigger_out pulses", 32'(trig_cnt - t0), 32'h0);
    wb_read(ADDR_STATUS, rd);
    check_eq("STATUS", rd, 32'(ARMED));
    // Channel b above the level but disabled
    en_mask = 4'b1101;
    wb_write(ADDR_CTRL, 32'h2);
    repeat (8) adc_push(rand_pair(8000, 1000), 1, 1'b0);
    adc_idle();
    en_mask = 4'hf;
    check_eq("trigger_out pulses", 32'(trig_cnt - t0), 32'h0);
    wb_read(ADDR_STATUS, rd);
    check_eq("STATUS", rd, 32'(ARMED));
    report_test("no_trigger", e0);
  endtask

  task automatic test_capture_a();
    int e0;
    e0 = errors;
    stim.delete();
    repeat (10) stim.push_back(rand_pair(0, 400));
    repeat (9) stim.push_back(rand_pair(600, 100));
    capture_run(0, 1000, 8, 1'b0);
    report_test("capture_a", e0);
  endtask

  task automatic test_channel_c();
    int e0;
    e0 = errors;
    stim.delete();
    repeat (6) stim.push_back(rand_pair(0, 400));
    repeat (7) stim.push_back(rand_pair(600, 100));
    capture_run(2, 1000, 6, 1'b1);
    report_test("channel_c", e0);
  endtask

  // Sums straddle the negative level so the model picks the edge
  task automatic test_negative_level();
    int e0;
    e0 = errors;
    stim.delete();
    repeat (30) stim.push_back(rand_pair(-2500, 150));
    capture_run(1, -5000, 4, 1'b0);
    report_test("negative_level", e0);
  endtask

  task automatic test_rearm_full();
    int          e0;
    logic [31:0] rd;
    e0 = errors;
    wb_read(ADDR_STATUS, rd);
    check_eq("STATUS before re-arm", rd, 32'((4 << 8) | int'(DONE)));
    stim.delete();
    repeat (4) stim.push_back(rand_pair(-100, 100));
    repeat (65) stim.push_back(rand_pair(600, 100));
    capture_run(0, 200, 0, 1'b0);
    report_test("rearm_full", e0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_i = '0;
    for (int k = 0; k < 4; k++) ch_in[k] = '0;
    repeat (16) @(posedge adc_clk);
    #5;
    rst_n = 1'b1;
    test_reset_values();
    test_no_trigger();
    test_capture_a();
    test_channel_c();
    test_negative_level();
    test_rearm_full();
    errors += i_trig_acq_top.i_trig_acq_chk.fail_cnt;
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* testbench/trig_acq_chk.sv */
`timescale 1ns/10ps
`include "trig_defines.svh"

module trig_acq_chk import trig_pkg::*; (
  input logic             adc_clk,
  input logic             rst_n,
  input logic             wb_cyc,
  input logic             wb_stb,
  input logic             wb_ack,
  input logic             trigger_out,
  input logic             wr_en,
  input acq_state_e       state,
  input logic [`CAP_AW:0] words,
  input acq_cfg_t         cfg
);

  // Assertion failures seen so far
  int fail_cnt = 0;

  logic [`CAP_AW:0] target;

  // Programmed count with zero meaning a full buffer
  assign target = (cfg.count == '0) ? (`CAP_AW+1)'(`CAP_DEPTH) : cfg.count;

  //////////////////////////////////////////////////////////////////////
  // Wishbone handshake
  //////////////////////////////////////////////////////////////////////

  ack_in_cycle: assert property (@(posedge adc_clk) disable iff (!rst_n)
    wb_ack |-> (wb_cyc && wb_stb))
    else begin fail_cnt++; $error("wb_ack outside of an active cycle"); end

  ack_single: assert property (@(posedge adc_clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else begin fail_cnt++; $error("wb_ack high for two cycles"); end

  //////////////////////////////////////////////////////////////////////
  // Trigger and capture
  //////////////////////////////////////////////////////////////////////

  trig_single: assert property (@(posedge adc_clk) disable iff (!rst_n)
    trigger_out |=> !trigger_out)
    else begin fail_cnt++; $error("trigger_out high for two cycles"); end

  // Word 0 goes in on the trigger edge, the rest while capturing
  wr_in_capture: assert property (@(posedge adc_clk) disable iff (!rst_n)
    wr_en |-> ((state == CAPTURE) || ((state == ARMED) && trigger_out)))
    else begin fail_cnt++; $error("buffer write outside of capture"); end

  wr_in_count: assert property (@(posedge adc_clk) disable iff (!rst_n)
    wr_en |-> (words < target))
    else begin fail_cnt++; $error("buffer write beyond the programmed count"); end

endmodule
